//--- design/armCtrl_cfg.svh
`ifndef ARMCTRL_CFG_SVH
`define ARMCTRL_CFG_SVH

// ======================================================================
// Core control widths
// ======================================================================

`define INSTR_W     32   // Full ARM instruction word
`define FLAGS_W     4    // NZCV
`define BYTE_LANES  4    // One strobe per byte of the data word
`define ALU_OP_W    4    // Same width as the DP opcode field

// Classic F/D/E/M/W pipe
`define PIPE_STAGES 5

`endif

//--- design/isaPkg.sv
`include "armCtrl_cfg.svh"

package isaPkg;

  // Raw instruction as fetched
  typedef logic [`INSTR_W-1:0] instrT;

  // Register file index, r0..r15
  typedef logic [3:0] regIdxT;
  localparam regIdxT PC_IDX = 4'd15;  // r15 is the PC

  // Condition field, bits 31:28
  typedef enum logic [3:0] {
    EQ = 4'b0000, NE = 4'b0001,   // Z set / clear
    CS = 4'b0010, CC = 4'b0011,   // C set / clear
    MI = 4'b0100, PL = 4'b0101,   // N set / clear
    VS = 4'b0110, VC = 4'b0111,   // V set / clear
    HI = 4'b1000, LS = 4'b1001,   // Unsigned higher / lower-or-same
    GE = 4'b1010, LT = 4'b1011,   // Signed compares
    GT = 4'b1100, LE = 4'b1101,
    AL = 4'b1110,                 // Always
    NV = 4'b1111                  // Never executes in this core
  } condT;

  // Data-processing opcode, bits 24:21
  // Doubles as the ALU control encoding
  typedef enum logic [`ALU_OP_W-1:0] {
    AND = 4'b0000, EOR = 4'b0001,
    SUB = 4'b0010, RSB = 4'b0011,
    ADD = 4'b0100, ADC = 4'b0101,
    SBC = 4'b0110, RSC = 4'b0111,
    TST = 4'b1000, TEQ = 4'b1001,  // Compare group, flags only
    CMP = 4'b1010, CMN = 4'b1011,
    ORR = 4'b1100, MOV = 4'b1101,
    BIC = 4'b1110, MVN = 4'b1111
  } dpOpT;

endpackage

//--- design/ctrlPkg.sv
`include "armCtrl_cfg.svh"

package ctrlPkg;
  import isaPkg::*;

  // NZCV, N in the top bit
  typedef logic [`FLAGS_W-1:0] flagsT;

  // Decode -> Execute bundle
  typedef struct packed {
    logic                 regWrite;
    logic                 memWrite;
    logic                 memtoReg;    // Result comes from data memory
    logic                 branch;
    logic                 pcSrc;       // Writes r15, branch or DP to PC
    logic                 aluSrc;      // 1 = immediate operand B
    logic                 byteAccess;  // LDRB/STRB
    logic                 setFlags;    // S bit
    logic                 logicOp;     // Keeps C and V on flag update
    logic                 noRegWrite;  // TST/TEQ/CMP/CMN
    logic [`ALU_OP_W-1:0] aluControl;
    condT                 cond;
  } decCtrlT;

  // Execute controls handed to the datapath
  typedef struct packed {
    logic                 aluSrc;
    logic [`ALU_OP_W-1:0] aluControl;
  } exCtrlT;

  // Memory-stage record, already condition gated
  typedef struct packed {
    logic       regWrite;
    logic       memtoReg;
    logic       pcSrc;
    logic       byteAccess;
    logic       setFlags;
    flagsT      flagsNext;
    logic [1:0] byteOffset;   // Low address bits for byte load alignment
  } memCtrlT;

  // Writeback-stage record
  typedef struct packed {
    logic       regWrite;
    logic       memtoReg;
    logic       pcSrc;
    logic       byteLoad;     // Byte access narrowed to loads
    logic       setFlags;
    flagsT      flagsNext;
    logic [1:0] byteOffset;
  } wbCtrlT;

endpackage

//--- design/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder
  import isaPkg::*, ctrlPkg::*;
(
  input  instrT      instrD,
  output decCtrlT    decCtrlD,
  output logic [1:0] regSrcD,   // [1] Rd as RA2 for STR, [0] PC as RA1 for B
  output logic [1:0] immSrcD,   // 00 imm8 rot, 01 imm12, 10 imm24
  output logic       pcSrcD
);

  dpOpT   opD;
  regIdxT rdD;
  logic   isDpD;      // Data processing, imm or reg
  logic   isLdStD;    // Legal LDR/STR/LDRB/STRB
  logic   isLoadD;
  logic   isBranchD;

  assign opD = dpOpT'(instrD[24:21]);
  assign rdD = regIdxT'(instrD[15:12]);

  // ======================================================================
  // Main decoder
  // ======================================================================

  always_comb begin
    // Defaults cover the undefined space
    isDpD     = 1'b0;
    isLdStD   = 1'b0;
    isBranchD = 1'b0;
    case (instrD[27:26])
      2'b00: isDpD = 1'b1;
      2'b01: begin
        // Register offset with bit 4 set is the media/undef space
        if (!(instrD[25] && instrD[4])) isLdStD = 1'b1;
      end
      2'b10: isBranchD = 1'b1;
      default: ;                 // Coprocessor/SWI, not handled here
    endcase
  end

  assign isLoadD = isLdStD & instrD[20];  // L bit

  always_comb begin
    decCtrlD = '0;
    regSrcD  = 2'b00;
    immSrcD  = 2'b00;
    if (isDpD) begin
      decCtrlD.aluSrc   = instrD[25];     // I bit
      decCtrlD.regWrite = 1'b1;           // Compare ops dropped later in Execute
    end else if (isLdStD) begin
      regSrcD             = isLoadD ? 2'b00 : 2'b10;  // STR reads Rd as data
      immSrcD             = 2'b01;
      decCtrlD.aluSrc     = ~instrD[25];  // Offset form inverts the I sense
      decCtrlD.regWrite   = isLoadD;
      decCtrlD.memtoReg   = isLoadD;
      decCtrlD.memWrite   = ~isLoadD;
      decCtrlD.byteAccess = instrD[22];   // B bit
    end else if (isBranchD) begin
      regSrcD         = 2'b01;            // PC as base
      immSrcD         = 2'b10;
      decCtrlD.aluSrc = 1'b1;
      decCtrlD.branch = 1'b1;
    end
    // Fields shared by every class
    decCtrlD.cond       = condT'(instrD[31:28]);
    decCtrlD.setFlags   = isDpD & instrD[20];
    decCtrlD.logicOp    = isDpD & (opD inside {AND, EOR, TST, TEQ, ORR, MOV, BIC, MVN});
    decCtrlD.noRegWrite = isDpD & (opD inside {TST, TEQ, CMP, CMN});
    decCtrlD.pcSrc      = pcSrcD;
    // ALU control
    if (isLdStD)    decCtrlD.aluControl = instrD[23] ? ADD : SUB;  // U bit picks offset sign
    else if (isDpD) decCtrlD.aluControl = opD;
    else            decCtrlD.aluControl = ADD;  // Branch target and undefined
  end

  // Writes to r15 count as a PC change, flag-only compares never do
  assign pcSrcD = (isDpD & ~(opD inside {TST, TEQ, CMP, CMN}) & (rdD == PC_IDX))
                | isLoadD & (rdD == PC_IDX)
                | isBranchD;

  // Load and store are separate classes across the whole decode table
  always_comb begin
    assert final (!(decCtrlD.memWrite && decCtrlD.memtoReg))
      else $error("decoder raised memWrite and memtoReg together");
  end

endmodule

//--- design/execStage.sv
`timescale 1ns/1ps
`include "armCtrl_cfg.svh"

module execStage
  import isaPkg::*, ctrlPkg::*;
(
  input  logic                   clk,
  input  logic                   arstN,
  input  logic                   stallE,
  input  logic                   flushE,
  input  decCtrlT                decCtrlD,
  input  flagsT                  aluFlagsE,   // Raw NZCV out of the ALU
  input  logic [1:0]             addrLowE,    // ALU result bits 1:0
  input  flagsT                  flagsFwdE,   // Current flags after forwarding
  output exCtrlT                 exCtrlE,
  output logic                   branchTakenE,
  output memCtrlT                memCtrlE,
  output logic                   memWriteE,
  output logic [`BYTE_LANES-1:0] byteMaskE,
  output logic                   pcSrcE
);

  decCtrlT ctrlQ;     // E pipeline register
  logic    condExE;   // Condition passed
  flagsT   flagsNextE;

  // ======================================================================
  // E register
  // ======================================================================

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ctrlQ <= '0;
    end else if (!stallE) begin
      ctrlQ <= flushE ? '0 : decCtrlD;   // Flush inserts a bubble
    end
  end

  // ARM condition table
  function automatic logic condPass(condT cond, flagsT f);
    logic n;
    logic z;
    logic c;
    logic v;
    {n, z, c, v} = f;
    case (cond)
      EQ: condPass = z;
      NE: condPass = ~z;
      CS: condPass = c;
      CC: condPass = ~c;
      MI: condPass = n;
      PL: condPass = ~n;
      VS: condPass = v;
      VC: condPass = ~v;
      HI: condPass = c & ~z;
      LS: condPass = ~c | z;
      GE: condPass = (n == v);
      LT: condPass = (n != v);
      GT: condPass = ~z & (n == v);
      LE: condPass = z | (n != v);
      AL: condPass = 1'b1;
      default: condPass = 1'b0;      // NV
    endcase
  endfunction

  assign condExE = condPass(ctrlQ.cond, flagsFwdE);

  // Logical ops leave C and V alone
  assign flagsNextE = ctrlQ.logicOp ? {aluFlagsE[3:2], flagsFwdE[1:0]} : aluFlagsE;

  // ======================================================================
  // Outputs
  // ======================================================================

  assign exCtrlE.aluSrc     = ctrlQ.aluSrc;
  assign exCtrlE.aluControl = ctrlQ.aluControl;

  assign branchTakenE = ctrlQ.branch & condExE;
  assign memWriteE    = ctrlQ.memWrite & condExE;
  assign pcSrcE       = ctrlQ.pcSrc;    // Ungated, PC write still possible

  // Word access strobes all lanes, byte access one lane
  assign byteMaskE = ctrlQ.byteAccess ? (`BYTE_LANES'(1) << addrLowE) : '1;

  // Record for the Memory stage
  assign memCtrlE.regWrite   = ctrlQ.regWrite & ~ctrlQ.noRegWrite & condExE;
  assign memCtrlE.memtoReg   = ctrlQ.memtoReg;
  assign memCtrlE.pcSrc      = ctrlQ.pcSrc & condExE;
  assign memCtrlE.byteAccess = ctrlQ.byteAccess;
  assign memCtrlE.setFlags   = ctrlQ.setFlags & condExE;
  assign memCtrlE.flagsNext  = flagsNextE;
  assign memCtrlE.byteOffset = addrLowE;

  // Store strobes must be a single lane or a full word
  assert property (@(posedge clk) disable iff (!arstN)
    memWriteE |-> ($onehot(byteMaskE) || (&byteMaskE)))
    else $error("illegal byte mask on store");

endmodule

//--- design/retireStage.sv
`timescale 1ns/1ps
`include "armCtrl_cfg.svh"

module retireStage
  import ctrlPkg::*;
(
  input  logic                   clk,
  input  logic                   arstN,
  input  logic                   stallM,
  input  logic                   flushM,
  input  logic                   stallW,
  input  logic                   flushW,
  input  memCtrlT                memCtrlE,
  input  logic                   memWriteE,
  input  logic [`BYTE_LANES-1:0] byteMaskE,
  output logic                   memWriteM,
  output logic [`BYTE_LANES-1:0] byteMaskM,
  output logic                   pcSrcM,
  output flagsT                  flagsFwdE,
  output logic                   regWriteW,
  output logic                   memtoRegW,
  output logic                   pcSrcW,
  output logic                   byteLoadW,
  output logic [1:0]             byteOffsetW,
  output flagsT                  flagsW
);

  memCtrlT memQ;    // M pipeline register
  wbCtrlT  wbQ;     // W pipeline register
  flagsT   flagsQ;  // Architectural NZCV

  // ======================================================================
  // M and W registers
  // ======================================================================

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      memQ      <= '0;
      memWriteM <= 1'b0;
      byteMaskM <= '0;
    end else if (!stallM) begin
      memQ      <= flushM ? '0 : memCtrlE;
      memWriteM <= flushM ? 1'b0 : memWriteE;
      byteMaskM <= flushM ? '0 : byteMaskE;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wbQ <= '0;
    end else if (!stallW) begin
      if (flushW) begin
        wbQ <= '0;
      end else begin
        wbQ.regWrite   <= memQ.regWrite;
        wbQ.memtoReg   <= memQ.memtoReg;
        wbQ.pcSrc      <= memQ.pcSrc;
        wbQ.byteLoad   <= memQ.byteAccess & memQ.memtoReg;  // LDRB only
        wbQ.setFlags   <= memQ.setFlags;
        wbQ.flagsNext  <= memQ.flagsNext;
        wbQ.byteOffset <= memQ.byteOffset;
      end
    end
  end

  // Flags commit as the instruction leaves W
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) flagsQ <= '0;
    else if (!stallW && wbQ.setFlags) flagsQ <= wbQ.flagsNext;
  end

  // Youngest pending update wins
  assign flagsFwdE = memQ.setFlags ? memQ.flagsNext :
                     wbQ.setFlags  ? wbQ.flagsNext  : flagsQ;

  // Flags as seen once the W instruction is applied
  assign flagsW = wbQ.setFlags ? wbQ.flagsNext : flagsQ;

  assign pcSrcM      = memQ.pcSrc;
  assign regWriteW   = wbQ.regWrite;
  assign memtoRegW   = wbQ.memtoReg;
  assign pcSrcW      = wbQ.pcSrc;
  assign byteLoadW   = wbQ.byteLoad;
  assign byteOffsetW = wbQ.byteOffset;

  // A held Writeback must not commit its flags twice or early
  assert property (@(posedge clk) disable iff (!arstN) stallW |=> $stable(flagsQ))
    else $error("flags changed during a Writeback stall");

endmodule

//--- design/armCtrl.sv
`timescale 1ns/1ps
`include "armCtrl_cfg.svh"

module armCtrl
  import isaPkg::*, ctrlPkg::*;
(
  input  logic                   clk,
  input  logic                   arstN,
  input  instrT                  instrD,
  input  flagsT                  aluFlagsE,
  input  logic [1:0]             addrLowE,
  input  logic                   stallE,
  input  logic                   stallM,
  input  logic                   stallW,
  input  logic                   flushE,
  input  logic                   flushM,
  input  logic                   flushW,
  output logic [1:0]             regSrcD,
  output logic [1:0]             immSrcD,
  output exCtrlT                 exCtrlE,
  output logic                   branchTakenE,
  output logic                   memWriteM,
  output logic [`BYTE_LANES-1:0] byteMaskM,
  output logic                   regWriteW,
  output logic                   memtoRegW,
  output logic                   pcSrcW,
  output logic                   byteLoadW,
  output logic [1:0]             byteOffsetW,
  output flagsT                  flagsW,
  output logic                   pcWrPendingF   // Hold fetch while r15 is in flight
);

  localparam int PendDepth = `PIPE_STAGES - 2;  // D, E and M

  decCtrlT                decCtrlD;
  memCtrlT                memCtrlE;
  logic                   memWriteE;
  logic [`BYTE_LANES-1:0] byteMaskE;
  flagsT                  flagsFwdE;
  logic                   pcSrcD;
  logic                   pcSrcE;
  logic                   pcSrcM;
  logic [PendDepth-1:0]   pcPend;

  instrDecoder dec0 (
    .instrD   (instrD),
    .decCtrlD (decCtrlD),
    .regSrcD  (regSrcD),
    .immSrcD  (immSrcD),
    .pcSrcD   (pcSrcD)
  );

  execStage exe0 (
    .clk          (clk),
    .arstN        (arstN),
    .stallE       (stallE),
    .flushE       (flushE),
    .decCtrlD     (decCtrlD),
    .aluFlagsE    (aluFlagsE),
    .addrLowE     (addrLowE),
    .flagsFwdE    (flagsFwdE),
    .exCtrlE      (exCtrlE),
    .branchTakenE (branchTakenE),
    .memCtrlE     (memCtrlE),
    .memWriteE    (memWriteE),
    .byteMaskE    (byteMaskE),
    .pcSrcE       (pcSrcE)
  );

  retireStage ret0 (
    .clk         (clk),
    .arstN       (arstN),
    .stallM      (stallM),
    .flushM      (flushM),
    .stallW      (stallW),
    .flushW      (flushW),
    .memCtrlE    (memCtrlE),
    .memWriteE   (memWriteE),
    .byteMaskE   (byteMaskE),
    .memWriteM   (memWriteM),
    .byteMaskM   (byteMaskM),
    .pcSrcM      (pcSrcM),
    .flagsFwdE   (flagsFwdE),
    .regWriteW   (regWriteW),
    .memtoRegW   (memtoRegW),
    .pcSrcW      (pcSrcW),
    .byteLoadW   (byteLoadW),
    .byteOffsetW (byteOffsetW),
    .flagsW      (flagsW)
  );

  // Any PC write still ahead of Writeback
  assign pcPend       = {pcSrcD, pcSrcE, pcSrcM};
  assign pcWrPendingF = |pcPend;

endmodule

//--- verif/armCtrlChecker.sv
`timescale 1ns/1ps
`include "armCtrl_cfg.svh"

module armCtrlChecker
  import ctrlPkg::*;
(
  input  logic                   clk,
  input  logic                   arstN,
  input  logic                   stallE,
  input  logic                   stallM,
  input  logic                   stallW,
  input  logic                   flushE,
  input  logic                   flushM,
  input  logic                   flushW,
  input  logic [34:0]            expRec,      // Record of the instruction now in Decode
  input  logic                   done,        // Stimulus drained
  input  logic [1:0]             regSrcD,
  input  logic [1:0]             immSrcD,
  input  exCtrlT                 exCtrlE,
  input  logic                   branchTakenE,
  input  logic                   memWriteM,
  input  logic [`BYTE_LANES-1:0] byteMaskM,
  input  logic                   regWriteW,
  input  logic                   memtoRegW,
  input  logic                   pcSrcW,
  input  logic                   byteLoadW,
  input  logic [1:0]             byteOffsetW,
  input  flagsT                  flagsW,
  input  logic                   pcWrPendingF,
  output int                     mismatches,
  output int                     testsOk,
  output int                     testsBad,
  output logic                   reportDone
);

  // Same layout as the testbench record
  typedef struct packed {
    logic       valid;        // 0 for idle slots and bubbles
    logic [7:0] test;
    logic [1:0] regSrc;
    logic [1:0] immSrc;
    logic       aluSrc;
    logic [3:0] aluCtl;
    logic       branchTaken;
    logic       memWrite;
    logic [3:0] byteMask;
    logic       regWrite;
    logic       memtoReg;
    logic       pcSrc;        // Condition gated
    logic       byteLoad;
    logic [1:0] byteOffset;
    logic [3:0] flags;
    logic       pcPend;       // Ungated PC write, Decode/Execute view
  } expRecT;

  expRecT dRec;
  expRecT eQ;    // Shadow E register
  expRecT mQ;    // Shadow M register
  expRecT wQ;    // Shadow W register
  int     testErr [256];
  int     curTest;

  assign dRec = expRec;

  // Bubble keeps the test id so late errors land somewhere useful
  function automatic expRecT bubbleOf(expRecT r);
    bubbleOf      = '0;
    bubbleOf.test = r.test;
  endfunction

  // ======================================================================
  // Shadow pipeline, same stall and flush rules as the DUT
  // ======================================================================

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      eQ <= '0;
      mQ <= '0;
      wQ <= '0;
    end else begin
      if (!stallE) eQ <= flushE ? bubbleOf(dRec) : dRec;
      if (!stallM) mQ <= flushM ? bubbleOf(eQ) : eQ;
      if (!stallW) wQ <= flushW ? bubbleOf(mQ) : mQ;
    end
  end

  task automatic checkField(input string name, input logic [7:0] test,
                            input logic [7:0] expV, input logic [7:0] gotV);
    if (expV !== gotV) begin
      $display("FAILED %0t: test %0d %s expected %0h got %0h",
               $time, test, name, expV, gotV);
      mismatches++;
      testErr[test]++;
    end
  endtask

  task automatic closeTest(input int t);
    if (testErr[t] == 0) begin
      $display("Test %0d done, all checks match", t);
      testsOk++;
    end else begin
      $display("Test %0d done, %0d mismatches", t, testErr[t]);
      testsBad++;
    end
  endtask

  // ======================================================================
  // Compare at the falling edge, all outputs settled
  // ======================================================================

  initial begin
    mismatches = 0;
    testsOk    = 0;
    testsBad   = 0;
    curTest    = -1;
    reportDone = 1'b0;
  end

  always @(negedge clk) begin
    if (arstN && !reportDone) begin
      if (dRec.valid) begin                            // Decode, combinational
        checkField("regSrcD", dRec.test, 8'(dRec.regSrc), 8'(regSrcD));
        checkField("immSrcD", dRec.test, 8'(dRec.immSrc), 8'(immSrcD));
      end
      if (eQ.valid) begin
        checkField("aluSrcE", eQ.test, 8'(eQ.aluSrc), 8'(exCtrlE.aluSrc));
        checkField("aluControlE", eQ.test, 8'(eQ.aluCtl), 8'(exCtrlE.aluControl));
      end
      checkField("branchTakenE", eQ.test, 8'(eQ.branchTaken), 8'(branchTakenE));
      checkField("memWriteM", mQ.test, 8'(mQ.memWrite), 8'(memWriteM));
      // Lane strobes only matter for a store that executes
      if (mQ.memWrite) checkField("byteMaskM", mQ.test, 8'(mQ.byteMask), 8'(byteMaskM));
      checkField("regWriteW", wQ.test, 8'(wQ.regWrite), 8'(regWriteW));
      checkField("memtoRegW", wQ.test, 8'(wQ.memtoReg), 8'(memtoRegW));
      checkField("pcSrcW", wQ.test, 8'(wQ.pcSrc), 8'(pcSrcW));
      checkField("byteLoadW", wQ.test, 8'(wQ.byteLoad), 8'(byteLoadW));
      if (wQ.valid) begin
        checkField("byteOffsetW", wQ.test, 8'(wQ.byteOffset), 8'(byteOffsetW));
        checkField("flagsW", wQ.test, 8'(wQ.flags), 8'(flagsW));
      end
      // Pending PC write seen from D, E (ungated) and M (gated)
      checkField("pcWrPendingF", dRec.test,
                 8'(dRec.pcPend | eQ.pcPend | mQ.pcSrc), 8'(pcWrPendingF));
      // A new test id in W means the previous one has fully retired
      if (wQ.valid && int'(wQ.test) != curTest) begin
        if (curTest >= 0) closeTest(curTest);
        curTest = int'(wQ.test);
      end
      if (done) begin
        if (curTest >= 0) closeTest(curTest);
        $display("Summary: %0d tests ok, %0d tests bad, %0d mismatches",
                 testsOk, testsBad, mismatches);
        reportDone = 1'b1;
      end
    end
  end

endmodule

//--- verif/armCtrlTb.sv
`timescale 1ns/1ps
`include "armCtrl_cfg.svh"

module armCtrlTb
  import isaPkg::*, ctrlPkg::*;
();

  localparam int    ClkPeriod   = 10;
  localparam int    ResetCycles = 5;
  localparam int    DrainCycles = 6;          // Enough for the last line to leave W
  localparam instrT IdleInstr   = 32'hF000_0000;  // ANDNV, never executes
  localparam string TracePath   = "verif/ctrl_trace.txt";

  // Expected record, layout shared with the checker
  typedef struct packed {
    logic       valid;
    logic [7:0] test;
    logic [1:0] regSrc;
    logic [1:0] immSrc;
    logic       aluSrc;
    logic [3:0] aluCtl;
    logic       branchTaken;
    logic       memWrite;
    logic [3:0] byteMask;
    logic       regWrite;
    logic       memtoReg;
    logic       pcSrc;
    logic       byteLoad;
    logic [1:0] byteOffset;
    logic [3:0] flags;
    logic       pcPend;
  } expRecT;

  typedef struct packed {
    instrT      instr;
    flagsT      aluFlags;     // For whatever sits in Execute this cycle
    logic [1:0] addrLow;
    logic [5:0] hazard;       // stallE stallM stallW flushE flushM flushW
    expRecT     exp;
  } stimT;

  logic                   clk;
  logic                   arstN;
  instrT                  instrD;
  flagsT                  aluFlagsE;
  logic [1:0]             addrLowE;
  logic                   stallE, stallM, stallW;
  logic                   flushE, flushM, flushW;
  logic [1:0]             regSrcD, immSrcD;
  exCtrlT                 exCtrlE;
  logic                   branchTakenE, memWriteM;
  logic [`BYTE_LANES-1:0] byteMaskM;
  logic                   regWriteW, memtoRegW, pcSrcW, byteLoadW;
  logic [1:0]             byteOffsetW;
  flagsT                  flagsW;
  logic                   pcWrPendingF;
  expRecT                 expRec;
  logic                   done;
  int                     mismatches, testsOk, testsBad;
  logic                   reportDone;
  stimT                   traceQ [$];
  int                     nLines;

  always #(ClkPeriod / 2) clk = ~clk;

  armCtrl dut0 (.*);

  armCtrlChecker chk0 (.expRec(expRec), .*);

  // ======================================================================
  // Trace reader and driver
  // ======================================================================

  task automatic loadTrace(output logic ok);
    int          fd;
    int          cnt;
    string       line;
    logic [31:0] f [24];
    stimT        s;
    ok = 1'b0;
    fd = $fopen(TracePath, "r");
    if (fd != 0) begin
      ok = 1'b1;
      while ($fgets(line, fd) != 0) begin
        if (line.len() < 4 || line.getc(0) == "#") continue;  // Blank or column notes
        cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
                      f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21],
                      f[22], f[23]);
        if (cnt != 24) begin
          $display("ERROR: trace line has %0d fields instead of 24: %s", cnt, line);
          ok = 1'b0;
        end
        s.instr           = f[0];
        s.aluFlags        = f[1][3:0];
        s.addrLow         = f[2][1:0];
        s.hazard          = {f[3][0], f[4][0], f[5][0], f[6][0], f[7][0], f[8][0]};
        s.exp.valid       = 1'b1;
        s.exp.test        = f[9][7:0];
        s.exp.regSrc      = f[10][1:0];
        s.exp.immSrc      = f[11][1:0];
        s.exp.aluSrc      = f[12][0];
        s.exp.aluCtl      = f[13][3:0];
        s.exp.branchTaken = f[14][0];
        s.exp.memWrite    = f[15][0];
        s.exp.byteMask    = f[16][3:0];
        s.exp.regWrite    = f[17][0];
        s.exp.memtoReg    = f[18][0];
        s.exp.pcSrc       = f[19][0];
        s.exp.byteLoad    = f[20][0];
        s.exp.byteOffset  = f[21][1:0];
        s.exp.flags       = f[22][3:0];
        s.exp.pcPend      = f[23][0];
        traceQ.push_back(s);
      end
      $fclose(fd);
    end
  endtask

  task automatic applyLine(input stimT s);
    instrD    = s.instr;
    aluFlagsE = s.aluFlags;
    addrLowE  = s.addrLow;
    {stallE, stallM, stallW, flushE, flushM, flushW} = s.hazard;
    expRec    = s.exp;
  endtask

  task automatic applyIdle();
    instrD    = IdleInstr;
    aluFlagsE = '0;
    addrLowE  = '0;
    {stallE, stallM, stallW, flushE, flushM, flushW} = '0;
    expRec    = '0;
  endtask

  initial begin : mainSeq
    logic ok;
    clk   = 1'b0;
    arstN = 1'b0;
    done  = 1'b0;
    applyIdle();
    loadTrace(ok);
    if (!ok || traceQ.size() == 0) begin
      $display("ERROR: the trace file could not be read or holds no stimulus");
      $display("test failed");
    end else begin
      nLines = traceQ.size();                       // Starts the watchdog
      repeat (ResetCycles) @(posedge clk);
      #1 arstN = 1'b1;
      foreach (traceQ[i]) begin
        applyLine(traceQ[i]);
        @(posedge clk);
        #1;
      end
      applyIdle();
      repeat (DrainCycles) @(posedge clk);
      #1 done = 1'b1;
      wait (reportDone);
      if (mismatches == 0 && testsBad == 0 && testsOk > 0) begin
        $display("test passed");
      end else begin
        $display("test failed");
      end
    end
    $finish;
  end

  // Trace length plus room for reset and drain
  initial begin : watchdog
    wait (nLines > 0);
    #((nLines + 20) * ClkPeriod);
    $display("ERROR: the run timed out before the checker finished");
    $display("test failed");
    $finish;
  end

endmodule

//--- verif/ctrl_trace.txt
# instr aluFlagsE addrLowE stallE stallM stallW flushE flushM flushW test | expected:
# regSrc immSrc aluSrc aluCtl brTaken memWrite byteMask regWrite memtoReg pcSrc byteLoad byteOff flags pcPend
E2821005 0 0 0 0 0 0 0 0 1 0 0 1 4 0 0 F 1 0 0 0 0 0 0
E0443005 0 0 0 0 0 0 0 0 1 0 0 0 2 0 0 F 1 0 0 0 0 0 0
E5976004 0 0 0 0 0 0 0 0 1 0 1 1 4 0 0 F 1 1 0 0 0 0 0
E5098008 0 0 0 0 0 0 0 0 1 2 1 1 2 0 1 F 0 0 0 0 0 0 0
EA000010 0 0 0 0 0 0 0 0 1 1 2 1 4 1 0 F 0 0 1 0 0 0 1
02811001 0 0 0 0 0 0 0 0 2 0 0 1 4 0 0 F 0 0 0 0 0 0 0
F5098008 0 0 0 0 0 0 0 0 2 2 1 1 2 0 0 F 0 0 0 0 0 0 0
0A000010 0 0 0 0 0 0 0 0 2 1 2 1 4 0 0 F 0 0 0 0 0 0 1
13A02003 0 0 0 0 0 0 0 0 2 0 0 1 D 0 0 F 1 0 0 0 0 0 0
E2911001 0 0 0 0 0 0 0 0 3 0 0 1 4 0 0 F 1 0 0 0 0 6 0
02822001 6 0 0 0 0 0 0 0 3 0 0 1 4 0 0 F 1 0 0 0 0 6 0
E3B03000 0 0 0 0 0 0 0 0 3 0 0 1 D 0 0 F 1 0 0 0 0 A 0
E3510000 B 0 0 0 0 0 0 0 3 0 0 1 A 0 0 F 0 0 0 0 0 2 0
22844001 2 0 0 0 0 0 0 0 3 0 0 1 4 0 0 F 1 0 0 0 0 2 0
E5C21000 0 0 0 0 0 0 0 0 4 2 1 1 4 0 1 1 0 0 0 0 0 2 0
E5C21001 0 0 0 0 0 0 0 0 4 2 1 1 4 0 1 2 0 0 0 0 1 2 0
E5C21002 0 1 0 0 0 0 0 0 4 2 1 1 4 0 1 4 0 0 0 0 2 2 0
E5C21003 0 2 0 0 0 0 0 0 4 2 1 1 4 0 1 8 0 0 0 0 3 2 0
E5821000 0 3 0 0 0 0 0 0 4 2 1 1 4 0 1 F 0 0 0 0 0 2 0
E5D25001 0 0 0 0 0 0 0 0 4 0 1 1 4 0 0 1 1 1 0 1 1 2 0
E2821005 0 1 0 0 0 0 0 0 5 0 0 1 4 0 0 F 1 0 0 0 0 2 0
E0443005 0 0 1 1 1 0 0 0 5 0 0 0 2 0 0 F 1 0 0 0 0 2 0
E0443005 0 0 0 0 0 0 0 0 5 0 0 0 2 0 0 F 1 0 0 0 0 2 0
E3821001 0 0 0 0 0 1 0 0 5 0 0 1 C 0 0 F 1 0 0 0 0 2 0
E3A07001 0 0 0 0 0 0 0 0 5 0 0 1 D 0 0 F 1 0 0 0 0 2 0
E2988001 0 0 0 0 0 0 1 0 5 0 0 1 4 0 0 F 1 0 0 0 0 8 0
E3A09002 8 0 0 0 0 0 0 0 5 0 0 1 D 0 0 F 1 0 0 0 0 2 0
E28AA003 0 0 0 0 0 0 0 1 5 0 0 1 4 0 0 F 1 0 0 0 0 2 0
E281F004 0 0 0 0 0 0 0 0 6 0 0 1 4 0 0 F 1 0 1 0 0 2 1
0281F004 0 0 0 0 0 0 0 0 6 0 0 1 4 0 0 F 0 0 0 0 0 2 1
1A000004 0 0 0 0 0 0 0 0 6 1 2 1 4 1 0 F 0 0 1 0 0 2 1

//--- src.f
+incdir+design
design/isaPkg.sv
design/ctrlPkg.sv
design/instrDecoder.sv
design/execStage.sv
design/retireStage.sv
design/armCtrl.sv
verif/armCtrlChecker.sv
verif/armCtrlTb.sv

//--- Makefile
TOP = armCtrlTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f src.f --top-module $(TOP) -o simv

# Pass or fail comes from the log, grep returns nonzero when the pass line is missing
run: build
	./obj_dir/simv | tee run.log
	grep -q "^test passed" run.log

lint:
	verilator --lint-only --timing -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir run.log
